//--- flist.f
common/emu_pkg.sv
controllers/pad_remap.sv
controllers/player_router.sv
backup/backup_ram.sv
backup/backup_sequencer.sv
logic/emu_glue.sv
bench/emu_checker.sv
bench/tb_emu.sv

//--- bench/tb_emu.sv
module tb_emu import emu_pkg::*; ();

	localparam int CYCLE_LIMIT = 30000; // Two full transfers, pad tests and slack

	logic       clk_sys = 1'b0;
	logic       reset;
	llapi_pad_t pad_a, pad_b;
	players_t   usb, players;
	logic       llapi_select, osd_status, osd_button;
	logic       cart_download, img_mounted, img_readonly;
	img_size_t  img_size;
	logic       bk_load_req, bk_save_req, autosave, format_req;
	bram_addr_t bram_addr;
	byte_t      bram_data, bram_q;
	logic       bram_wr;
	lba_t       sd_lba;
	logic       sd_rd, sd_wr, sd_ack, sd_buff_wr;
	buff_addr_t sd_buff_addr;
	word_t      sd_buff_dout, sd_buff_din;
	logic       bk_busy, bk_loading, bk_led;

	logic [31:0] lcg_state = 32'd89;
	int          cycles = 0;
	logic        seen_a_m, seen_b_m;   // Expected seen flags
	word_t       ram_model [4096];     // Host view, word s*256+w
	word_t       fmt_words [4] = '{16'h5548, 16'h4D42, 16'h8800, 16'h8010};

	emu_glue dut (.*);

	bind emu_glue emu_checker u_checker (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.sd_rd      (sd_rd),
		.sd_wr      (sd_wr),
		.sd_ack     (sd_ack),
		.bk_busy    (bk_busy),
		.bk_loading (bk_loading)
	);

	always #20 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (dut.u_checker.failures != 0) begin
			$display("A bound assertion on the backup strobes failed");
			$display("*** FAILED ***");
			$fatal(1, "Run stopped by a checker assertion");
		end else if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: no result after %0d cycles", CYCLE_LIMIT);
			$display("*** FAILED ***");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	// ========================================
	// Models
	// ========================================

	// Upper halves of two steps, low LCG bits repeat too soon
	function automatic logic [31:0] rand_next();
		logic [31:0] hi;
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		hi = lcg_state;
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return {hi[31:16], lcg_state[31:16]};
	endfunction

	function automatic joy_t remap_model(input pad_type_t t, input pad_buttons_t b);
		int   src [8]; // Source bits for VI V IV III Run Select II I
		joy_t j;
		if (t == 8'd20 || t == 8'd21)
			src = '{6, 3, 2, 0, 5, 4, 1, 7};
		else if (t == 8'd54 || t == 8'd23)
			src = '{3, 2, 8, 9, 5, 4, 0, 1};
		else if (t == 8'd8 || t == 8'd3)
			src = '{6, 3, 2, 0, 5, 9, 1, 7};
		else
			src = '{7, 3, 6, 2, 5, 4, 0, 1};
		for (int i = 0; i < 8; i++)
			j[11 - i] = b[src[i]];
		j[3:0] = b[27:24];
		return j;
	endfunction

	function automatic players_t route_model(input logic pres_a, input logic pres_b,
			input joy_t ja, input joy_t jb, input players_t u);
		if (pres_a && pres_b)
			return {u.slot2, u.slot1, u.slot0, jb, ja};
		else if (pres_a)
			return {u.slot3, u.slot2, u.slot1, u.slot0, ja};
		else if (pres_b)
			return {u.slot3, u.slot2, u.slot1, jb, u.slot0};
		return u;
	endfunction

	function automatic logic chord_model(input pad_buttons_t b);
		return b[26] && b[5] && b[0];
	endfunction

	function automatic llapi_pad_t rand_pad(input logic en);
		pad_type_t   codes [6] = '{8'd20, 8'd21, 8'd54, 8'd23, 8'd8, 8'd3};
		llapi_pad_t  p;
		logic [31:0] r;
		r = rand_next();
		p.en = en;
		p.buttons = rand_next();
		if (r % 7 < 6)
			p.pad_type = codes[r % 7];
		else
			p.pad_type = 8'd100 + r[15:11]; // Outside every family
		return p;
	endfunction

	function automatic players_t rand_usb();
		logic [63:0] r;
		r = {rand_next(), rand_next()};
		return r[59:0];
	endfunction

	// ========================================
	// Driver tasks
	// ========================================

	task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("error at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic apply_reset();
		@(posedge clk_sys);
		reset <= 1'b1;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
		seen_a_m = 1'b0;
		seen_b_m = 1'b0;
	endtask

	task automatic pad_step(input llapi_pad_t a, input llapi_pad_t b, input players_t u);
		logic pres_a;
		logic pres_b;
		@(posedge clk_sys);
		pad_a <= a;
		pad_b <= b;
		usb   <= u;
		@(negedge clk_sys);
		pres_a = a.en && llapi_select && (a.pad_type != 0 || seen_a_m);
		pres_b = b.en && llapi_select && (b.pad_type != 0 || seen_b_m);
		compare(players, route_model(pres_a, pres_b, remap_model(a.pad_type, a.buttons),
			remap_model(b.pad_type, b.buttons), u), "player slots");
		compare(osd_button, !osd_status && (chord_model(a.buttons) || chord_model(b.buttons)),
			"osd button");
		seen_a_m = seen_a_m || (a.buttons != 0); // Flags follow on the next edge
		seen_b_m = seen_b_m || (b.buttons != 0);
	endtask

	task automatic read_core(input bram_addr_t a);
		word_t w;
		@(posedge clk_sys);
		bram_addr <= a;
		@(posedge clk_sys);
		@(negedge clk_sys);
		w = ram_model[a[10:1]];
		compare(bram_q, a[0] ? w[15:8] : w[7:0], "core read byte");
	endtask

	// Host side of the sector handshake, 16 sectors
	task automatic serve_transfer(input logic is_load);
		word_t w;
		for (int s = 0; s < BK_SECTORS; s++) begin
			do @(negedge clk_sys); while (!(sd_rd || sd_wr));
			compare(sd_rd, is_load, "read strobe");
			compare(sd_wr, !is_load, "write strobe");
			compare(sd_lba, s, "sector lba");
			@(posedge clk_sys);
			sd_ack <= 1'b1;
			for (int i = 0; i <= 256; i++) begin
				w = word_t'(rand_next());
				@(posedge clk_sys);
				sd_buff_addr <= buff_addr_t'(i);
				sd_buff_wr   <= is_load && i < 256;
				sd_buff_dout <= w;
				if (is_load && i < 256)
					ram_model[s * 256 + i] = w;
				@(negedge clk_sys);
				if (!is_load && i > 0) // Read data lags the address by one
					compare(sd_buff_din, ram_model[s * 256 + i - 1], "saved word");
				compare(bk_loading, is_load, "loading flag");
				compare(bk_busy, 1'b1, "busy flag");
				compare(bk_led, 1'b1, "backup led");
			end
			@(posedge clk_sys);
			sd_ack <= 1'b0;
		end
	endtask

	task automatic wait_idle();
		do @(negedge clk_sys); while (bk_busy);
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		llapi_pad_t pa, pb, pa0;
		bram_addr_t addr;
		byte_t      data;
		reset = 1'b1;
		pad_a = '0;
		pad_b = '0;
		usb = '0;
		llapi_select = 1'b0;
		osd_status = 1'b0;
		cart_download = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b1;
		img_size = '0;
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		autosave = 1'b0;
		format_req = 1'b0;
		bram_addr = '0;
		bram_data = '0;
		bram_wr = 1'b0;
		sd_ack = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr = 1'b0;
		apply_reset();

		// Remap and slots
		@(posedge clk_sys);
		llapi_select <= 1'b1;
		repeat (60) pad_step(rand_pad(1'b1), rand_pad(1'b1), rand_usb());
		repeat (30) pad_step(rand_pad(1'b0), rand_pad(1'b1), rand_usb());
		repeat (30) pad_step(rand_pad(1'b1), rand_pad(1'b0), rand_usb());

		// OSD chord on either pad, or missing
		for (int i = 0; i < 40; i++) begin
			pa = rand_pad(1'b1);
			pb = rand_pad(1'b1);
			if (i % 4 == 0) begin
				pa.buttons |= 32'h0400_0021;
			end else if (i % 4 == 1) begin
				pb.buttons |= 32'h0400_0021;
			end else begin
				pa.buttons[0] = 1'b0;
				pb.buttons[0] = 1'b0;
			end
			pad_step(pa, pb, rand_usb());
		end
		@(posedge clk_sys);
		osd_status <= 1'b1;
		pa.buttons |= 32'h0400_0021;
		pad_step(pa, pb, rand_usb()); // Menu already open
		@(posedge clk_sys);
		osd_status <= 1'b0;

		// Presence by button on a type 0 pad
		pa0 = '{en: 1'b1, pad_type: '0, buttons: '0};
		pad_step(pa0, pa0, rand_usb());
		apply_reset();
		pad_step(pa0, pa0, rand_usb());
		pa = pa0;
		pa.buttons = rand_next() | 32'h1;
		pad_step(pa, pa0, rand_usb());
		repeat (4) pad_step(pa0, pa0, rand_usb());
		apply_reset();
		pad_step(pa0, pa0, rand_usb());
		@(posedge clk_sys);
		llapi_select <= 1'b0;
		repeat (10) pad_step(rand_pad(1'b1), rand_pad(1'b1), rand_usb());

		// ========================================
		// Backup RAM
		// ========================================

		// Download with a writable image, autoload fills the whole RAM
		@(posedge clk_sys);
		img_mounted   <= 1'b1;
		img_readonly  <= 1'b0;
		img_size      <= 64'd32768;
		cart_download <= 1'b1;
		repeat (5) @(posedge clk_sys);
		cart_download <= 1'b0;
		serve_transfer(1'b1);
		wait_idle();
		compare(bk_loading, 1'b0, "loading flag after load");
		repeat (40) read_core(bram_addr_t'(rand_next()));

		@(posedge clk_sys);
		format_req <= 1'b1;
		@(posedge clk_sys);
		format_req <= 1'b0;
		repeat (8) @(posedge clk_sys); // Four header writes done by now
		for (int i = 0; i < 4; i++)
			ram_model[i] = fmt_words[i];
		for (int i = 0; i < 8; i++)
			read_core(bram_addr_t'(i));

		// Core writes with autosave on, then a full save
		@(posedge clk_sys);
		autosave <= 1'b1;
		for (int i = 0; i < 32; i++) begin
			addr = bram_addr_t'(rand_next());
			data = byte_t'(rand_next());
			@(posedge clk_sys);
			bram_addr <= addr;
			bram_data <= data;
			bram_wr   <= 1'b1;
			if (addr[0])
				ram_model[addr[10:1]][15:8] = data;
			else
				ram_model[addr[10:1]][7:0] = data;
		end
		@(posedge clk_sys);
		bram_wr     <= 1'b0;
		bk_save_req <= 1'b1;
		@(negedge clk_sys);
		compare(bk_led, 1'b1, "led with save pending");
		@(posedge clk_sys);
		bk_save_req <= 1'b0;
		serve_transfer(1'b0);
		wait_idle();
		compare(sd_rd || sd_wr, 1'b0, "strobe after save");
		compare(bk_led, 1'b0, "led after save");

		repeat (5) @(posedge clk_sys);
		if (dut.u_checker.failures == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			$display("*** FAILED ***");
			$fatal(1, "Checker assertions failed");
		end
	end

endmodule

//--- bench/emu_checker.sv
module emu_checker (
	input logic clk_sys,
	input logic reset,
	input logic sd_rd,
	input logic sd_wr,
	input logic sd_ack,
	input logic bk_busy,
	input logic bk_loading
);

	int failures = 0; // Failed assertions so far

	// ========================================
	// Host strobes
	// ========================================

	a_one_strobe: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr))
		else begin
			$error("sd_rd and sd_wr are high together");
			failures++;
		end

	// New request only after the host drops ack
	a_no_rise_in_ack: assert property (@(posedge clk_sys) disable iff (reset)
		sd_ack |-> !$rose(sd_rd) && !$rose(sd_wr))
		else begin
			$error("strobe rose while sd_ack was high");
			failures++;
		end

	a_loading_busy: assert property (@(posedge clk_sys) disable iff (reset)
		bk_loading |-> bk_busy)
		else begin
			$error("bk_loading high without bk_busy");
			failures++;
		end

endmodule

//--- logic/emu_glue.sv
module emu_glue import emu_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	// Serial and USB pads
	input  llapi_pad_t pad_a,
	input  llapi_pad_t pad_b,
	input  players_t   usb,
	input  logic       llapi_select,
	output players_t   players,
	output logic       osd_button,
	// Menu and download state
	input  logic       osd_status,
	input  logic       cart_download,
	input  logic       img_mounted,
	input  logic       img_readonly,
	input  img_size_t  img_size,
	input  logic       bk_load_req,
	input  logic       bk_save_req,
	input  logic       autosave,
	input  logic       format_req,
	// Core backup RAM port
	input  bram_addr_t bram_addr,
	input  byte_t      bram_data,
	input  logic       bram_wr,
	output byte_t      bram_q,
	// Host sector port
	output lba_t       sd_lba,
	output logic       sd_rd,
	output logic       sd_wr,
	input  logic       sd_ack,
	input  buff_addr_t sd_buff_addr,
	input  word_t      sd_buff_dout,
	output word_t      sd_buff_din,
	input  logic       sd_buff_wr,
	output logic       bk_busy,
	output logic       bk_loading,
	output logic       bk_led
);

	host_port_t host;

	player_router u_router (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.llapi_select (llapi_select),
		.osd_status   (osd_status),
		.pad_a        (pad_a),
		.pad_b        (pad_b),
		.usb          (usb),
		.players      (players),
		.osd_button   (osd_button)
	);

	backup_sequencer u_seq (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.bk_load_req   (bk_load_req),
		.bk_save_req   (bk_save_req),
		.autosave      (autosave),
		.format_req    (format_req),
		.osd_status    (osd_status),
		.core_we       (bram_wr),
		.sd_ack        (sd_ack),
		.sd_buff_addr  (sd_buff_addr),
		.sd_buff_dout  (sd_buff_dout),
		.sd_buff_wr    (sd_buff_wr),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.host          (host),
		.bk_busy       (bk_busy),
		.bk_loading    (bk_loading),
		.bk_led        (bk_led)
	);

	backup_ram u_ram (
		.clk_sys    (clk_sys),
		.core_addr  (bram_addr),
		.core_wdata (bram_data),
		.core_we    (bram_wr),
		.core_q     (bram_q),
		.host       (host),
		.host_q     (sd_buff_din)
	);

endmodule

//--- backup/backup_sequencer.sv
module backup_sequencer import emu_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       cart_download,
	input  logic       img_mounted,
	input  logic       img_readonly,
	input  img_size_t  img_size,
	input  logic       bk_load_req,
	input  logic       bk_save_req,
	input  logic       autosave,
	input  logic       format_req,
	input  logic       osd_status,
	input  logic       core_we,
	input  logic       sd_ack,
	input  buff_addr_t sd_buff_addr,
	input  word_t      sd_buff_dout,
	input  logic       sd_buff_wr,
	output lba_t       sd_lba,
	output logic       sd_rd,
	output logic       sd_wr,
	output host_port_t host,
	output logic       bk_busy,
	output logic       bk_loading,
	output logic       bk_led
);

	bk_state_t  state;
	sector_t    sector;
	logic       bk_ena;
	logic       pending;
	logic [2:0] fmt_cnt;   // Bit 2 set when no format is running
	logic       dl_d;
	logic       load_d;
	logic       save_d;
	logic       ack_d;
	logic       fmt_d;
	logic       save_trig;
	logic       load_rise;
	logic       save_rise;
	logic       ack_rise;
	logic       ack_fall;
	logic       dl_rise;
	logic       dl_fall;

	assign save_trig = bk_save_req | (pending & osd_status & autosave);

	assign load_rise = bk_load_req & ~load_d;
	assign save_rise = save_trig & ~save_d;
	assign ack_rise  = sd_ack & ~ack_d;
	assign ack_fall  = ~sd_ack & ack_d;
	assign dl_rise   = cart_download & ~dl_d;
	assign dl_fall   = ~cart_download & dl_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			{dl_d, load_d, save_d, ack_d, fmt_d} <= '0;
		end else begin
			dl_d   <= cart_download;
			load_d <= bk_load_req;
			save_d <= save_trig;
			ack_d  <= sd_ack;
			fmt_d  <= format_req;
		end
	end

	// ========================================
	// Enable and pending save
	// ========================================

	// Save image is mounted by the end of every download
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena <= 1'b0;
		end else begin
			if (dl_rise) bk_ena <= 1'b0;
			if (cart_download & img_mounted & ~img_readonly) bk_ena <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pending <= 1'b0;
		end else if (bk_ena & ~osd_status & core_we) begin
			pending <= 1'b1;
		end else if (bk_busy) begin
			pending <= 1'b0;
		end
	end

	// ========================================
	// Transfer FSM
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= BK_IDLE;
			sector     <= '0;
			bk_loading <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
		end else begin
			if (ack_rise) begin
				sd_rd <= 1'b0; // Host took the request
				sd_wr <= 1'b0;
			end
			case (state)
				BK_IDLE: begin
					if (bk_ena & dl_fall & (|img_size)) begin
						state      <= BK_XFER; // Autoload
						sector     <= '0;
						bk_loading <= 1'b1;
						sd_rd      <= 1'b1;
						sd_wr      <= 1'b0;
					end else if (bk_ena & (load_rise | save_rise)) begin
						state      <= BK_XFER;
						sector     <= '0;
						bk_loading <= load_rise;
						sd_rd      <= load_rise;
						sd_wr      <= ~load_rise;
					end
				end
				BK_XFER: begin
					if (ack_fall) begin
						if (sector == sector_t'(BK_SECTORS - 1)) begin
							state      <= BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sector <= sector + 1'b1;
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

	assign sd_lba  = lba_t'(sector);
	assign bk_busy = (state == BK_XFER);
	assign bk_led  = bk_busy | (autosave & pending);

	// ========================================
	// Format and host port
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			fmt_cnt <= 3'b100;
		end else if (format_req & ~fmt_d) begin
			fmt_cnt <= '0;
		end else if (~fmt_cnt[2]) begin
			fmt_cnt <= fmt_cnt + 1'b1;
		end
	end

	always_comb begin
		if (~fmt_cnt[2]) begin
			host.addr  = ram_addr_t'(fmt_cnt[1:0]);
			host.wdata = FORMAT_WORDS[fmt_cnt[1:0]];
			host.we    = 1'b1;
		end else begin
			host.addr  = {sector, sd_buff_addr};
			host.wdata = sd_buff_dout;
			host.we    = sd_buff_wr & sd_ack;
		end
	end

endmodule

//--- backup/backup_ram.sv
module backup_ram import emu_pkg::*; (
	input  logic       clk_sys,
	input  bram_addr_t core_addr,
	input  byte_t      core_wdata,
	input  logic       core_we,
	output byte_t      core_q,
	input  host_port_t host,
	output word_t      host_q
);

	ram_addr_t core_word;

	assign core_word = {2'b00, core_addr[10:1]};

	// ========================================
	// Byte banks, bank 0 holds even bytes
	// ========================================

	for (genvar i = 0; i < 2; i++) begin : g_bank
		byte_t mem [4096];
		byte_t q_core;
		byte_t q_host;
		logic  core_sel;

		assign core_sel = (core_addr[0] == i[0]);

		always_ff @(posedge clk_sys) begin
			if (core_we & core_sel) begin // Core side
				mem[core_word] <= core_wdata;
			end
			if (host.we) begin // Host side, one lane of the word
				mem[host.addr] <= host.wdata[8*i +: 8];
			end
			q_core <= mem[core_word];
			q_host <= mem[host.addr];
		end
	end

	// Lane pick follows the address held through the read
	assign core_q = core_addr[0] ? g_bank[1].q_core : g_bank[0].q_core;
	assign host_q = {g_bank[1].q_host, g_bank[0].q_host};

endmodule

//--- controllers/player_router.sv
module player_router import emu_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       llapi_select,
	input  logic       osd_status,
	input  llapi_pad_t pad_a,
	input  llapi_pad_t pad_b,
	input  players_t   usb,
	output players_t   players,
	output logic       osd_button
);

	joy_t joy_a;
	joy_t joy_b;
	logic seen_a;
	logic seen_b;
	logic present_a;
	logic present_b;

	// Menu chord is d-pad bit 26 with buttons 5 and 0
	function automatic logic chord(input pad_buttons_t b);
		return b[26] & b[5] & b[0];
	endfunction

	pad_remap u_remap_a (
		.pad (pad_a),
		.joy (joy_a)
	);

	pad_remap u_remap_b (
		.pad (pad_b),
		.joy (joy_b)
	);

	// ========================================
	// Presence
	// ========================================

	// Type 0 may still be a real pad, trust it once a button shows up
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			seen_a <= 1'b0;
			seen_b <= 1'b0;
		end else begin
			if (|pad_a.buttons) seen_a <= 1'b1;
			if (|pad_b.buttons) seen_b <= 1'b1;
		end
	end

	assign present_a = pad_a.en & llapi_select & ((|pad_a.pad_type) | seen_a);
	assign present_b = pad_b.en & llapi_select & ((|pad_b.pad_type) | seen_b);

	// ========================================
	// Slot assignment
	// ========================================

	always_comb begin
		players = usb; // No serial pads
		if (present_a & present_b) begin
			players.slot0 = joy_a;
			players.slot1 = joy_b;
			players.slot2 = usb.slot0;
			players.slot3 = usb.slot1;
			players.slot4 = usb.slot2;
		end else if (present_a ^ present_b) begin
			players.slot0 = present_a ? joy_a : usb.slot0;
			players.slot1 = present_b ? joy_b : usb.slot0;
			players.slot2 = usb.slot1;
			players.slot3 = usb.slot2;
			players.slot4 = usb.slot3;
		end
	end

	// Chord opens the menu, ignored while the menu is already up
	assign osd_button = ~osd_status & (chord(pad_a.buttons) | chord(pad_b.buttons));

endmodule

//--- controllers/pad_remap.sv
module pad_remap import emu_pkg::*; (
	input  llapi_pad_t pad,
	output joy_t       joy
);

	pad_buttons_t b;

	assign b = pad.buttons;

	// ========================================
	// Layout per device family
	// ========================================

	always_comb begin
		case (pad.pad_type)
			TYPE_GENESIS_A, TYPE_GENESIS_B: begin
				joy = {
					b[6], b[3], b[2], b[0], // VI V IV III
					b[5], b[4],             // Run Select
					b[1], b[7],             // II I
					b[27:24]
				};
			end
			TYPE_TG16_A, TYPE_TG16_B: begin
				joy = {
					b[3], b[2], b[8], b[9],
					b[5], b[4],
					b[0], b[1],
					b[27:24]
				};
			end
			TYPE_SATURN_A, TYPE_SATURN_B: begin
				// Genesis order, Select moved to the right trigger
				joy = {
					b[6], b[3], b[2], b[0],
					b[5], b[9],
					b[1], b[7],
					b[27:24]
				};
			end
			default: begin
				joy = {
					b[7], b[3], b[6], b[2],
					b[5], b[4],
					b[0], b[1],
					b[27:24]
				};
			end
		endcase
	end

endmodule

//--- common/emu_pkg.sv
package emu_pkg;

	// ========================================
	// Widths
	// ========================================

	typedef logic [11:0] joy_t;         // VI V IV III Run Select II I, then d-pad
	typedef logic [31:0] pad_buttons_t;
	typedef logic [7:0]  pad_type_t;
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] word_t;
	typedef logic [10:0] bram_addr_t;   // Core byte address
	typedef logic [11:0] ram_addr_t;    // Word address inside one bank
	typedef logic [7:0]  buff_addr_t;   // Word within a sector
	typedef logic [3:0]  sector_t;
	typedef logic [31:0] lba_t;
	typedef logic [63:0] img_size_t;

	// ========================================
	// Bundles
	// ========================================

	// Slot 0 sits in the low bits
	typedef struct packed {
		joy_t slot4;
		joy_t slot3;
		joy_t slot2;
		joy_t slot1;
		joy_t slot0;
	} players_t;

	// One serial pad report
	typedef struct packed {
		logic         en;
		pad_type_t    pad_type;
		pad_buttons_t buttons;
	} llapi_pad_t;

	// Sequencer command to the host side of the backup RAM
	typedef struct packed {
		ram_addr_t addr;
		word_t     wdata;
		logic      we;
	} host_port_t;

	typedef enum logic {
		BK_IDLE,
		BK_XFER
	} bk_state_t;

	// ========================================
	// Constants
	// ========================================

	localparam int BK_SECTORS = 16;

	localparam pad_type_t TYPE_GENESIS_A = 8'd20;
	localparam pad_type_t TYPE_GENESIS_B = 8'd21;
	localparam pad_type_t TYPE_TG16_A    = 8'd54;
	localparam pad_type_t TYPE_TG16_B    = 8'd23;
	localparam pad_type_t TYPE_SATURN_A  = 8'd8;
	localparam pad_type_t TYPE_SATURN_B  = 8'd3;

	// Empty backup RAM header, index 0 first
	localparam word_t [0:3] FORMAT_WORDS = {
		16'h5548,
		16'h4D42,
		16'h8800,
		16'h8010
	};

endpackage
